//--- axi_bridge.f
+incdir+logic
logic/axi_pkg.sv
logic/refill_pkg.sv
logic/rd_cmd_if.sv
logic/read_arbiter.sv
logic/write_engine.sv
logic/return_router.sv
logic/axi_bridge_top.sv
bench/axi_bridge_chk.sv
bench/axi_bridge_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= axi_bridge_tb
OBJ_DIR ?= obj_dir
FILELIST ?= axi_bridge.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := logic/axi_bridge_defs.svh
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/axi_bridge_tb.sv
`timescale 1ns/1ns
`include "axi_bridge_defs.svh"

module axi_bridge_tb;

    localparam int NUM_EACH = 60;                       // accepted requests per source
    localparam int TIMEOUT_CYCLES = 200 * 3 * NUM_EACH + 16;

    logic clk = 1'b0;
    logic rst_n;
    logic icache_rd_req, icache_rd_rdy, icache_ret_valid, icache_ret_last;
    logic dcache_rd_req, dcache_rd_rdy, dcache_ret_valid, dcache_ret_last;
    logic dcache_wr_req, dcache_wr_rdy;
    refill_pkg::req_type_t icache_rd_type, dcache_rd_type, dcache_wr_type;
    axi_pkg::addr_t icache_rd_addr, dcache_rd_addr, dcache_wr_addr;
    axi_pkg::word_t icache_ret_data, dcache_ret_data;
    axi_pkg::strb_t dcache_wr_wstrb;
    refill_pkg::line_t dcache_wr_data;
    axi_pkg::id_t arid, rid, awid, bid;
    axi_pkg::addr_t araddr, awaddr;
    axi_pkg::len_t arlen, awlen;
    axi_pkg::size_t arsize, awsize;
    logic [1:0] arburst, arlock, awburst, awlock, rresp, bresp;
    logic [3:0] arcache, awcache;
    logic [2:0] arprot, awprot;
    logic arvalid, arready, rlast, rvalid, rready, awvalid, awready;
    logic wlast, wvalid, wready, bvalid, bready;
    axi_pkg::word_t rdata, wdata;
    axi_pkg::strb_t wstrb;

    logic [31:0] rng = 32'd17;
    axi_pkg::word_t mem [axi_pkg::addr_t];              // written words of the slave
    axi_pkg::id_t exp_ar_id[$];
    axi_pkg::addr_t exp_ar_addr[$];
    axi_pkg::len_t exp_ar_len[$];
    axi_pkg::size_t exp_ar_size[$];
    logic [32:0] exp_i[$];                              // {last, data}
    logic [32:0] exp_d[$];
    axi_pkg::addr_t exp_aw_addr[$];
    axi_pkg::len_t exp_aw_len[$];
    axi_pkg::size_t exp_aw_size[$];
    logic [36:0] exp_w[$];                              // {last, strb, data}
    logic r_act [2];
    axi_pkg::addr_t r_addr [2];
    int r_left [2];
    axi_pkg::addr_t wr_base;
    int w_beat;
    logic b_pend = 1'b0;
    logic wr_busy = 1'b0;
    logic d_busy = 1'b0;
    logic i_acc, d_acc, w_acc;
    int i_cnt = 0;
    int d_cnt = 0;
    int w_cnt = 0;

    axi_bridge_top axi_bridge_top_inst (.*);

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // unwritten words read back as address xor pattern
    function automatic axi_pkg::word_t mem_word(input axi_pkg::addr_t addr);
        axi_pkg::addr_t a;
        a = {addr[31:2], 2'b00};
        if (mem.exists(a)) return mem[a];
        return a ^ 32'hA5A5_0000;
    endfunction

    function automatic refill_pkg::req_type_t pick_type(input logic [2:0] r);
        if (r[0]) return `RD_TYPE_LINE;
        if (r[2:1] == 2'b11) return 3'b010;             // no 8-byte beats
        return {1'b0, r[2:1]};
    endfunction

    function automatic axi_pkg::addr_t pick_addr(input axi_pkg::addr_t base,
                                                 input refill_pkg::req_type_t t);
        logic [31:0] r;
        r = next_rand();
        if (t == `RD_TYPE_LINE) return base | (r & 32'h0000_00F0);
        return base | (r & 32'h0000_00FC);
    endfunction

    task automatic fail_plain(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "check %s", name);
        end
    endtask

    task automatic queue_read(input logic data_side, input refill_pkg::req_type_t t,
                              input axi_pkg::addr_t addr);
        int n;
        int k;
        logic [32:0] beat;
        n = (t == `RD_TYPE_LINE) ? `LINE_BEATS : 1;
        exp_ar_id.push_back(data_side ? `ID_DATA : `ID_INST);
        exp_ar_addr.push_back(addr);
        exp_ar_len.push_back(axi_pkg::len_t'(n - 1));
        exp_ar_size.push_back((t == `RD_TYPE_LINE) ? 3'd2 : {1'b0, t[1:0]});
        for (k = 0; k < n; k++) begin
            beat = {k == n - 1, mem_word(addr + 32'(4 * k))};   // consecutive words
            if (data_side) exp_d.push_back(beat);
            else exp_i.push_back(beat);
        end
    endtask

    task automatic queue_write();
        int k;
        exp_aw_addr.push_back(dcache_wr_addr);
        if (dcache_wr_type == `RD_TYPE_LINE) begin
            exp_aw_len.push_back(8'd3);
            exp_aw_size.push_back(3'd2);
            for (k = 0; k < `LINE_BEATS; k++)
                exp_w.push_back({k == 3, 4'hF, dcache_wr_data[32 * k +: 32]});
        end else begin
            exp_aw_len.push_back(8'd0);
            exp_aw_size.push_back({1'b0, dcache_wr_type[1:0]});
            exp_w.push_back({1'b1, dcache_wr_wstrb, dcache_wr_data[31:0]});
        end
    endtask

    // sample at the rising edge, before the DUT registers update
    task automatic observe();
        logic [32:0] beat;
        logic [36:0] wbeat;
        axi_pkg::word_t merged;
        axi_pkg::addr_t a;
        int id;
        int b;
        i_acc = icache_rd_req & icache_rd_rdy;
        d_acc = dcache_rd_req & dcache_rd_rdy;
        w_acc = dcache_wr_req & dcache_wr_rdy;
        check("rready tied high", 1, rready);
        if (icache_rd_req && dcache_rd_req && dcache_rd_rdy)
            check("data read wins a tie", 0, icache_rd_rdy);
        if (wr_busy || w_acc) check("dcache_rd_rdy low during write", 0, dcache_rd_rdy);
        if (d_busy) check("dcache_rd_rdy low while data read open", 0, dcache_rd_rdy);
        if (icache_ret_valid) begin
            if (exp_i.size() == 0) fail_plain("icache got a beat it did not ask for");
            beat = exp_i.pop_front();
            check("icache return", beat, {icache_ret_last, icache_ret_data});
        end
        if (dcache_ret_valid) begin
            if (exp_d.size() == 0) fail_plain("dcache got a beat it did not ask for");
            beat = exp_d.pop_front();
            check("dcache return", beat, {dcache_ret_last, dcache_ret_data});
            if (dcache_ret_last) d_busy = 1'b0;
        end
        if (rvalid) begin
            id = int'(rid[0]);
            r_addr[id] = r_addr[id] + 32'd4;
            r_left[id] = r_left[id] - 1;
            if (r_left[id] == 0) r_act[id] = 1'b0;
        end
        if (arvalid && arready) begin
            if (exp_ar_id.size() == 0) fail_plain("ar request with no read accepted");
            check("arid", exp_ar_id.pop_front(), arid);
            check("araddr", exp_ar_addr.pop_front(), araddr);
            check("arlen", exp_ar_len.pop_front(), arlen);
            check("arsize", exp_ar_size.pop_front(), arsize);
            check("arburst", `BURST_INCR, arburst);
            check("arlock", 0, arlock);
            check("arcache", 0, arcache);
            check("arprot", 0, arprot);
            id = int'(arid[0]);
            r_act[id] = 1'b1;
            r_addr[id] = araddr;
            r_left[id] = int'(arlen) + 1;
        end
        if (awvalid && awready) begin
            if (exp_aw_addr.size() == 0) fail_plain("aw request with no write accepted");
            check("awid", 1, awid);
            check("awaddr", exp_aw_addr.pop_front(), awaddr);
            check("awlen", exp_aw_len.pop_front(), awlen);
            check("awsize", exp_aw_size.pop_front(), awsize);
            check("awburst", `BURST_INCR, awburst);
            check("awlock", 0, awlock);
            check("awcache", 0, awcache);
            check("awprot", 0, awprot);
            wr_base = awaddr;
            w_beat = 0;
        end
        if (wvalid && wready) begin
            if (exp_w.size() == 0) fail_plain("w beat with no write accepted");
            wbeat = exp_w.pop_front();
            check("w beat", wbeat, {wlast, wstrb, wdata});
            a = wr_base + 32'(4 * w_beat);
            merged = mem_word(a);
            for (b = 0; b < 4; b++)
                if (wstrb[b]) merged[8 * b +: 8] = wdata[8 * b +: 8];
            mem[{a[31:2], 2'b00}] = merged;
            w_beat++;
            if (wlast) b_pend = 1'b1;
        end
        if (bvalid && bready) begin
            b_pend = 1'b0;
            wr_busy = 1'b0;
        end
        if (i_acc) begin
            queue_read(1'b0, icache_rd_type, icache_rd_addr);
            i_cnt++;
        end
        if (d_acc) begin
            queue_read(1'b1, dcache_rd_type, dcache_rd_addr);
            d_busy = 1'b1;
            d_cnt++;
        end
        if (w_acc) begin
            queue_write();
            wr_busy = 1'b1;
            w_cnt++;
        end
    endtask

    task automatic drive();
        logic [31:0] r;
        int id;
        if (i_acc) icache_rd_req = 1'b0;
        if (d_acc) dcache_rd_req = 1'b0;
        if (w_acc) dcache_wr_req = 1'b0;
        r = next_rand();
        arready = |r[1:0];                              // random stalls
        awready = |r[3:2];
        wready = |r[5:4];
        bvalid = b_pend & (bvalid | r[6]);
        rvalid = 1'b0;
        rlast = 1'b0;
        if ((r_act[0] || r_act[1]) && r[9:8] != 2'b00) begin
            id = (r_act[0] && r_act[1]) ? int'(r[7]) : int'(r_act[1]);  // interleave ids
            rvalid = 1'b1;
            rid = axi_pkg::id_t'(id);
            rdata = mem_word(r_addr[id]);
            rlast = (r_left[id] == 1);
        end
        r = next_rand();
        if (!icache_rd_req && i_cnt < NUM_EACH && r[1:0] == 2'b00) begin
            icache_rd_req = 1'b1;
            icache_rd_type = pick_type(r[4:2]);
            icache_rd_addr = pick_addr(32'h1000_0000, icache_rd_type);
        end
        if (!dcache_rd_req && !d_busy && d_cnt < NUM_EACH && r[6:5] == 2'b00) begin
            dcache_rd_req = 1'b1;
            dcache_rd_type = pick_type(r[9:7]);
            dcache_rd_addr = pick_addr(32'h2000_0000, dcache_rd_type);
        end
        // no write while a data read is open, so its data is already fixed
        if (!dcache_wr_req && !wr_busy && !d_busy && !dcache_rd_req && w_cnt < NUM_EACH
            && r[12:10] == 3'b000) begin
            dcache_wr_req = 1'b1;
            dcache_wr_type = r[13] ? `RD_TYPE_LINE : 3'b010;
            dcache_wr_addr = pick_addr(32'h2000_0000, dcache_wr_type);
            dcache_wr_wstrb = r[17:14] | 4'b0001;
            dcache_wr_data = {next_rand(), next_rand(), next_rand(), next_rand()};
        end
    endtask

    function automatic logic all_done();
        return i_cnt == NUM_EACH && d_cnt == NUM_EACH && w_cnt == NUM_EACH
            && !icache_rd_req && !dcache_rd_req && !dcache_wr_req
            && exp_i.size() == 0 && exp_d.size() == 0 && exp_w.size() == 0
            && !r_act[0] && !r_act[1] && !b_pend && !wr_busy;
    endfunction

    initial begin
        #(TIMEOUT_CYCLES * 4);
        $display("watchdog: transactions did not complete in time");
        $display("Something failed");
        $fatal(1, "timeout");
    end

    initial begin
        rst_n = 1'b0;
        {icache_rd_req, dcache_rd_req, dcache_wr_req} = '0;
        {icache_rd_type, dcache_rd_type, dcache_wr_type} = '0;
        {icache_rd_addr, dcache_rd_addr, dcache_wr_addr} = '0;
        dcache_wr_wstrb = '0;
        dcache_wr_data = '0;
        {arready, awready, wready, rvalid, rlast, bvalid} = '0;
        {rid, bid, rresp, bresp} = '0;
        rdata = '0;
        r_act[0] = 1'b0;
        r_act[1] = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        check("reset arvalid", 0, arvalid);
        check("reset awvalid", 0, awvalid);
        check("reset wvalid", 0, wvalid);
        check("reset bready", 0, bready);
        check("reset icache_ret_valid", 0, icache_ret_valid);
        check("reset dcache_ret_valid", 0, dcache_ret_valid);
        check("reset icache_rd_rdy", 1, icache_rd_rdy);
        check("reset dcache_rd_rdy", 1, dcache_rd_rdy);
        check("reset dcache_wr_rdy", 1, dcache_wr_rdy);
        rst_n = 1'b1;
        while (!all_done()) begin
            @(posedge clk);
            observe();
            #1;
            drive();
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- bench/axi_bridge_chk.sv
`timescale 1ns/1ns

module axi_bridge_chk (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  arvalid,
    input logic                  arready,
    input axi_pkg::addr_t        araddr,
    input logic                  wvalid,
    input logic                  wready,
    input axi_pkg::word_t        wdata,
    input logic                  wlast,
    input logic                  bvalid,
    input logic                  bready,
    input refill_pkg::wr_state_t state
);

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped or araddr changed before arready");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wlast))
        else $error("wvalid dropped or wdata or wlast changed before wready");

    // the burst ends with the wlast beat
    wlast_end: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && wready && wlast |=> !wvalid)
        else $error("wvalid still high after the wlast beat");

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bready && !bvalid |=> bready)
        else $error("bready dropped before bvalid");

    b_done: assert property (@(posedge clk) disable iff (!rst_n)
        bready && bvalid |=> state == refill_pkg::st_idle)
        else $error("write engine not idle after the b handshake");

endmodule

bind axi_bridge_top axi_bridge_chk axi_bridge_chk_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .wlast   (wlast),
    .bvalid  (bvalid),
    .bready  (bready),
    .state   (write_engine_inst.state)
);

//--- logic/axi_bridge_top.sv
`timescale 1ns/1ns
`include "axi_bridge_defs.svh"

module axi_bridge_top (
    input  logic                  clk,
    input  logic                  rst_n,
    // instruction cache read
    input  logic                  icache_rd_req,
    input  refill_pkg::req_type_t icache_rd_type,
    input  axi_pkg::addr_t        icache_rd_addr,
    output logic                  icache_rd_rdy,
    output logic                  icache_ret_valid,
    output logic                  icache_ret_last,
    output axi_pkg::word_t        icache_ret_data,
    // data cache read
    input  logic                  dcache_rd_req,
    input  refill_pkg::req_type_t dcache_rd_type,
    input  axi_pkg::addr_t        dcache_rd_addr,
    output logic                  dcache_rd_rdy,
    output logic                  dcache_ret_valid,
    output logic                  dcache_ret_last,
    output axi_pkg::word_t        dcache_ret_data,
    // data cache write
    input  logic                  dcache_wr_req,
    input  refill_pkg::req_type_t dcache_wr_type,
    input  axi_pkg::addr_t        dcache_wr_addr,
    input  axi_pkg::strb_t        dcache_wr_wstrb,
    input  refill_pkg::line_t     dcache_wr_data,
    output logic                  dcache_wr_rdy,
    // axi read address
    output axi_pkg::id_t          arid,
    output axi_pkg::addr_t        araddr,
    output axi_pkg::len_t         arlen,
    output axi_pkg::size_t        arsize,
    output logic [1:0]            arburst,
    output logic [1:0]            arlock,
    output logic [3:0]            arcache,
    output logic [2:0]            arprot,
    output logic                  arvalid,
    input  logic                  arready,
    // axi read data
    input  axi_pkg::id_t          rid,
    input  axi_pkg::word_t        rdata,
    input  logic [1:0]            rresp,   // not checked
    input  logic                  rlast,
    input  logic                  rvalid,
    output logic                  rready,
    // axi write address
    output axi_pkg::id_t          awid,
    output axi_pkg::addr_t        awaddr,
    output axi_pkg::len_t         awlen,
    output axi_pkg::size_t        awsize,
    output logic [1:0]            awburst,
    output logic [1:0]            awlock,
    output logic [3:0]            awcache,
    output logic [2:0]            awprot,
    output logic                  awvalid,
    input  logic                  awready,
    // axi write data
    output axi_pkg::word_t        wdata,
    output axi_pkg::strb_t        wstrb,
    output logic                  wlast,
    output logic                  wvalid,
    input  logic                  wready,
    // axi write response
    input  axi_pkg::id_t          bid,     // not checked
    input  logic [1:0]            bresp,   // not checked
    input  logic                  bvalid,
    output logic                  bready
);

    logic write_pending;

    rd_cmd_if rd_cmd ();

    assign arburst = `BURST_INCR;
    assign arlock  = '0;
    assign arcache = '0;
    assign arprot  = '0;
    assign awid    = `ID_WRITE;
    assign awburst = `BURST_INCR;
    assign awlock  = '0;
    assign awcache = '0;
    assign awprot  = '0;
    assign rready  = 1'b1;   // both caches always take returned data

    read_arbiter read_arbiter_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .icache_rd_req  (icache_rd_req),
        .dcache_rd_req  (dcache_rd_req),
        .icache_rd_type (icache_rd_type),
        .dcache_rd_type (dcache_rd_type),
        .icache_rd_addr (icache_rd_addr),
        .dcache_rd_addr (dcache_rd_addr),
        .write_pending  (write_pending),
        .icache_rd_rdy  (icache_rd_rdy),
        .dcache_rd_rdy  (dcache_rd_rdy),
        .arid           (arid),
        .araddr         (araddr),
        .arlen          (arlen),
        .arsize         (arsize),
        .arvalid        (arvalid),
        .arready        (arready),
        .cmd            (rd_cmd.arb)
    );

    write_engine write_engine_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .wr_req         (dcache_wr_req),
        .wr_type        (dcache_wr_type),
        .wr_addr        (dcache_wr_addr),
        .wr_wstrb       (dcache_wr_wstrb),
        .wr_data        (dcache_wr_data),
        .wr_rdy         (dcache_wr_rdy),
        .write_pending  (write_pending),
        .awaddr         (awaddr),
        .awlen          (awlen),
        .awsize         (awsize),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wlast          (wlast),
        .wvalid         (wvalid),
        .wready         (wready),
        .bvalid         (bvalid),
        .bready         (bready)
    );

    return_router return_router_inst (
        .clk              (clk),
        .rst_n            (rst_n),
        .rid              (rid),
        .rdata            (rdata),
        .rlast            (rlast),
        .rvalid           (rvalid),
        .icache_ret_valid (icache_ret_valid),
        .icache_ret_last  (icache_ret_last),
        .dcache_ret_valid (dcache_ret_valid),
        .dcache_ret_last  (dcache_ret_last),
        .icache_ret_data  (icache_ret_data),
        .dcache_ret_data  (dcache_ret_data),
        .cmd              (rd_cmd.rtr)
    );

endmodule

//--- logic/return_router.sv
`timescale 1ns/1ns
`include "axi_bridge_defs.svh"

module return_router (
    input  logic           clk,
    input  logic           rst_n,
    input  axi_pkg::id_t   rid,
    input  axi_pkg::word_t rdata,
    input  logic           rlast,
    input  logic           rvalid,
    output logic           icache_ret_valid,
    output logic           icache_ret_last,
    output logic           dcache_ret_valid,
    output logic           dcache_ret_last,
    output axi_pkg::word_t icache_ret_data,
    output axi_pkg::word_t dcache_ret_data,
    rd_cmd_if.rtr          cmd
);

    logic [1:0] beat_cnt [2];   // beats seen per read id
    logic       slot;           // 0 instruction, 1 data
    logic       beat;
    logic       final_beat;

    assign icache_ret_valid = rvalid & (rid == `ID_INST);
    assign dcache_ret_valid = rvalid & (rid == `ID_DATA);
    assign icache_ret_last  = icache_ret_valid & rlast;
    assign dcache_ret_last  = dcache_ret_valid & rlast;
    assign icache_ret_data  = rdata;
    assign dcache_ret_data  = rdata;

    assign slot       = (rid == `ID_DATA);
    assign beat       = icache_ret_valid | dcache_ret_valid;
    // a line never runs past its fourth beat
    assign final_beat = beat & (rlast | (beat_cnt[slot] == 2'(`LINE_BEATS - 1)));

    assign cmd.done    = final_beat;
    assign cmd.done_id = rid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt[0] <= '0;
            beat_cnt[1] <= '0;
        end else begin
            if (cmd.issue) begin
                beat_cnt[cmd.issue_id == `ID_DATA] <= '0;  // fresh read on this id
            end
            if (final_beat) begin
                beat_cnt[slot] <= '0;
            end else if (beat) begin
                beat_cnt[slot] <= beat_cnt[slot] + 1'b1;
            end
        end
    end

endmodule

//--- logic/write_engine.sv
`timescale 1ns/1ns
`include "axi_bridge_defs.svh"

module write_engine (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_req,
    input  refill_pkg::req_type_t wr_type,
    input  axi_pkg::addr_t        wr_addr,
    input  axi_pkg::strb_t        wr_wstrb,
    input  refill_pkg::line_t     wr_data,
    output logic                  wr_rdy,
    output logic                  write_pending,
    output axi_pkg::addr_t        awaddr,
    output axi_pkg::len_t         awlen,
    output axi_pkg::size_t        awsize,
    output logic                  awvalid,
    input  logic                  awready,
    output axi_pkg::word_t        wdata,
    output axi_pkg::strb_t        wstrb,
    output logic                  wlast,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready
);

    refill_pkg::wr_state_t state;
    refill_pkg::wr_state_t state_nxt;
    refill_pkg::line_t     line_q;   // shifts down one word per beat
    axi_pkg::len_t         beat_cnt;
    logic                  accept;
    logic                  w_fire;

    assign wr_rdy        = (state == refill_pkg::st_idle);
    assign accept        = wr_req & wr_rdy;
    // also covers the accept cycle itself
    assign write_pending = accept | (state != refill_pkg::st_idle);

    assign awvalid = (state == refill_pkg::st_addr);
    assign wvalid  = (state == refill_pkg::st_data);
    assign wdata   = line_q[31:0];
    assign wlast   = wvalid & (beat_cnt == awlen);
    assign bready  = (state == refill_pkg::st_resp);
    assign w_fire  = wvalid & wready;

    always_comb begin
        state_nxt = state;
        case (state)
            refill_pkg::st_idle: if (accept) state_nxt = refill_pkg::st_addr;
            refill_pkg::st_addr: if (awready) state_nxt = refill_pkg::st_data;
            refill_pkg::st_data: if (w_fire && wlast) state_nxt = refill_pkg::st_resp;
            refill_pkg::st_resp: if (bvalid) state_nxt = refill_pkg::st_idle;
            default:             state_nxt = refill_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= refill_pkg::st_idle;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                beat_cnt <= '0;
            end else if (w_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            awaddr <= wr_addr;
            line_q <= wr_data;
            if (wr_type == `RD_TYPE_LINE) begin
                awlen  <= axi_pkg::len_t'(`LINE_BEATS - 1);
                awsize <= {1'b0, `SIZE_WORD};
                wstrb  <= '1;                  // whole line, all bytes
            end else begin
                awlen  <= '0;
                awsize <= {1'b0, wr_type[1:0]};
                wstrb  <= wr_wstrb;
            end
        end else if (w_fire) begin
            line_q <= line_q >> 32;            // next word to the bottom
        end
    end

endmodule

//--- logic/read_arbiter.sv
`timescale 1ns/1ns
`include "axi_bridge_defs.svh"

module read_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  icache_rd_req,
    input  logic                  dcache_rd_req,
    input  refill_pkg::req_type_t icache_rd_type,
    input  refill_pkg::req_type_t dcache_rd_type,
    input  axi_pkg::addr_t        icache_rd_addr,
    input  axi_pkg::addr_t        dcache_rd_addr,
    input  logic                  write_pending,
    output logic                  icache_rd_rdy,
    output logic                  dcache_rd_rdy,
    output axi_pkg::id_t          arid,
    output axi_pkg::addr_t        araddr,
    output axi_pkg::len_t         arlen,
    output axi_pkg::size_t        arsize,
    output logic                  arvalid,
    input  logic                  arready,
    rd_cmd_if.arb                 cmd
);

    logic                  busy_inst;  // instruction read outstanding
    logic                  busy_data;  // data read outstanding
    logic                  grant_data;
    logic                  grant_inst;
    refill_pkg::req_type_t sel_type;
    axi_pkg::addr_t        sel_addr;

    // data reads never pass a pending write
    assign dcache_rd_rdy = ~arvalid & ~busy_data & ~write_pending;
    assign grant_data    = dcache_rd_req & dcache_rd_rdy;
    // dcache wins a tie, so icache is turned away in that cycle
    assign icache_rd_rdy = ~arvalid & ~busy_inst & ~grant_data;
    assign grant_inst    = icache_rd_req & icache_rd_rdy;

    assign sel_type = grant_data ? dcache_rd_type : icache_rd_type;
    assign sel_addr = grant_data ? dcache_rd_addr : icache_rd_addr;

    assign cmd.issue    = arvalid & arready;
    assign cmd.issue_id = arid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arvalid   <= 1'b0;
            busy_inst <= 1'b0;
            busy_data <= 1'b0;
        end else begin
            if (cmd.issue) begin
                arvalid <= 1'b0;
            end else if (grant_data | grant_inst) begin
                arvalid <= 1'b1;
            end
            if (grant_inst) begin
                busy_inst <= 1'b1;
            end else if (cmd.done && cmd.done_id == `ID_INST) begin
                busy_inst <= 1'b0;
            end
            if (grant_data) begin
                busy_data <= 1'b1;
            end else if (cmd.done && cmd.done_id == `ID_DATA) begin
                busy_data <= 1'b0;
            end
        end
    end

    // ar holding register, frozen while arvalid waits
    always_ff @(posedge clk) begin
        if (grant_data | grant_inst) begin
            arid   <= grant_data ? `ID_DATA : `ID_INST;
            araddr <= sel_addr;
            if (sel_type == `RD_TYPE_LINE) begin
                arlen  <= axi_pkg::len_t'(`LINE_BEATS - 1);
                arsize <= {1'b0, `SIZE_WORD};
            end else begin
                arlen  <= '0;                   // single beat
                arsize <= {1'b0, sel_type[1:0]};
            end
        end
    end

endmodule

//--- logic/rd_cmd_if.sv
`timescale 1ns/1ns

interface rd_cmd_if;

    logic            issue;    // ar handshake pulse
    axi_pkg::id_t    issue_id; // id of the read just issued
    logic            done;     // last beat of a read seen
    axi_pkg::id_t    done_id;  // id of the finished read

    modport arb (
        output issue,
        output issue_id,
        input  done,
        input  done_id
    );

    modport rtr (
        input  issue,
        input  issue_id,
        output done,
        output done_id
    );

endinterface

//--- logic/refill_pkg.sv
package refill_pkg;

    // rd_type / wr_type from the caches
    typedef logic [2:0] req_type_t;

    // one 16-byte cache line
    typedef logic [127:0] line_t;

    // write engine states
    typedef enum logic [1:0] {
        st_idle, // waiting for a cache write
        st_addr, // aw request presented
        st_data, // w beats going out
        st_resp  // waiting for b
    } wr_state_t;

endpackage

//--- logic/axi_pkg.sv
package axi_pkg;

    // byte address on ar/aw
    typedef logic [31:0] addr_t;

    // one 32-bit data beat
    typedef logic [31:0] word_t;

    // transaction id
    typedef logic [3:0] id_t;

    // beats minus one
    typedef logic [7:0] len_t;

    // log2 of bytes per beat
    typedef logic [2:0] size_t;

    // byte enables of one beat
    typedef logic [3:0] strb_t;

endpackage

//--- logic/axi_bridge_defs.svh
`ifndef AXI_BRIDGE_DEFS_SVH
`define AXI_BRIDGE_DEFS_SVH

// cache line geometry
`define LINE_BEATS 4

// fixed transaction ids
`define ID_INST 4'd0
`define ID_DATA 4'd1
`define ID_WRITE 4'd1

// axi burst type
`define BURST_INCR 2'b01

// cache request type of a full line
`define RD_TYPE_LINE 3'b100

// log2 bytes of one 32-bit beat
`define SIZE_WORD 2'b10

`endif
